/* Bender.yml */
package:
  name: issue_cluster

sources:
  - files:
      - common/ooo_pkg.sv
      - rs/rs_station.sv
      - logic/alu_unit.sv
      - logic/mul_unit.sv
      - logic/cdb_arbiter.sv
      - logic/issue_cluster.sv
  - target: test
    files:
      - sim/clock_gen.sv
      - sim/issue_cluster_properties.sv
      - sim/issue_cluster_tb.sv

/* common/ooo_pkg.sv */
package ooo_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////

    localparam int xlen       = 32;  // data word
    localparam int prf_len    = 6;   // physical register tag
    localparam int rob_len    = 5;   // reorder buffer index
    localparam int rs_size    = 4;   // entries per station
    localparam int rs_len     = 2;   // entry index width
    localparam int mul_stages = 3;   // multiplier latency in cycles

    //////////////////////////////
    // operation encodings
    //////////////////////////////

    // integer alu ops
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,   // signed compare, 1 or 0
        alu_sll,
        alu_srl
    } alu_op_t;

    // multiply ops, low word or high word of the 64-bit product
    typedef enum logic [1:0] {
        mul_mul,     // low word
        mul_mulh,    // high, signed x signed
        mul_mulhsu,  // high, signed x unsigned
        mul_mulhu    // high, unsigned x unsigned
    } mul_op_t;

    // lane steering
    typedef enum logic {
        fu_alu,
        fu_mul
    } fu_sel_t;

    //////////////////////////////
    // buses
    //////////////////////////////

    // source operand; value field holds the tag while not ready
    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] value;
    } operand_t;

    // renamed instruction from dispatch
    typedef struct packed {
        fu_sel_t            fu_sel;
        alu_op_t            alu_op;
        mul_op_t            mul_op;
        operand_t           opa;
        operand_t           opb;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } dispatch_t;

    // one broadcast on the common data bus
    typedef struct packed {
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
        logic [xlen-1:0]    value;
    } cdb_t;

    // station output for the alu lane
    typedef struct packed {
        alu_op_t            op;
        logic [xlen-1:0]    opa;
        logic [xlen-1:0]    opb;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } alu_issue_t;

    // station output for the multiply lane, same field order
    typedef struct packed {
        mul_op_t            op;
        logic [xlen-1:0]    opa;
        logic [xlen-1:0]    opb;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } mul_issue_t;

    // unit result toward the arbiter
    typedef struct packed {
        logic valid;
        cdb_t cdb;
    } result_t;

endpackage

/* flist.f */
common/ooo_pkg.sv
rs/rs_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/issue_cluster.sv
sim/clock_gen.sv
sim/issue_cluster_properties.sv
sim/issue_cluster_tb.sv

/* logic/alu_unit.sv */
module alu_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                issue_valid,
    input  ooo_pkg::alu_issue_t issue_pkt,
    input  logic                grant,    // arbiter took the held result
    output ooo_pkg::result_t    result,
    output logic                free      // station may issue this cycle
);

    logic [ooo_pkg::xlen-1:0] alu_out;
    logic                     hold_valid;
    ooo_pkg::cdb_t            hold_cdb;

    //////////////////////////////
    // datapath
    //////////////////////////////

    always_comb begin
        case (issue_pkt.op)
            ooo_pkg::alu_add: alu_out = issue_pkt.opa + issue_pkt.opb;
            ooo_pkg::alu_sub: alu_out = issue_pkt.opa - issue_pkt.opb;
            ooo_pkg::alu_and: alu_out = issue_pkt.opa & issue_pkt.opb;
            ooo_pkg::alu_or:  alu_out = issue_pkt.opa | issue_pkt.opb;
            ooo_pkg::alu_xor: alu_out = issue_pkt.opa ^ issue_pkt.opb;
            ooo_pkg::alu_slt: // signed less-than
                alu_out = {{(ooo_pkg::xlen-1){1'b0}},
                           $signed(issue_pkt.opa) < $signed(issue_pkt.opb)};
            ooo_pkg::alu_sll:
                alu_out = issue_pkt.opa << issue_pkt.opb[$clog2(ooo_pkg::xlen)-1:0];
            ooo_pkg::alu_srl:
                alu_out = issue_pkt.opa >> issue_pkt.opb[$clog2(ooo_pkg::xlen)-1:0];
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////
    // holding register
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hold_valid <= 1'b0;
        end else if (flush) begin
            hold_valid <= 1'b0;   // result in flight is dropped
        end else if (issue_valid) begin
            hold_valid <= 1'b1;   // only arrives when the old one left
        end else if (grant) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) hold_cdb <= {issue_pkt.dest_preg, issue_pkt.rob_idx, alu_out};
    end

    assign result = {hold_valid, hold_cdb};

    // an issue already on its way fills the register next cycle, so wait for it
    assign free = !issue_valid && (!hold_valid || grant);

endmodule

/* logic/cdb_arbiter.sv */
module cdb_arbiter (
    input  ooo_pkg::result_t mul_result,  // never stalls, always first
    input  ooo_pkg::result_t alu_result,  // waits in its holding register
    output logic             cdb_valid,
    output ooo_pkg::cdb_t    cdb,
    output logic             alu_grant
);

    //////////////////////////////
    // fixed priority, mul over alu
    //////////////////////////////

    // any lane with a result puts it on the bus
    assign cdb_valid = mul_result.valid || alu_result.valid;

    // payload mux
    always_comb begin
        if (mul_result.valid) begin
            cdb = mul_result.cdb;
        end else begin
            cdb = alu_result.cdb;   // also the idle value, qualified by cdb_valid
        end
    end

    // alu leaves its register only when it actually drove the bus
    assign alu_grant = alu_result.valid && !mul_result.valid;

endmodule

/* logic/issue_cluster.sv */
module issue_cluster (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               dispatch_valid,
    input  ooo_pkg::dispatch_t dispatch,
    output logic               alu_full,
    output logic               mul_full,
    output logic               cdb_valid,
    output ooo_pkg::cdb_t      cdb
);

    logic                alu_enable;
    logic                mul_enable;
    logic                alu_issue_valid;
    logic                mul_issue_valid;
    ooo_pkg::alu_issue_t alu_issue_pkt;
    ooo_pkg::mul_issue_t mul_issue_pkt;
    logic                alu_free;
    logic                alu_grant;
    ooo_pkg::result_t    alu_result;
    ooo_pkg::result_t    mul_result;

    // steer dispatch by lane
    assign alu_enable = dispatch_valid && (dispatch.fu_sel == ooo_pkg::fu_alu);
    assign mul_enable = dispatch_valid && (dispatch.fu_sel == ooo_pkg::fu_mul);

    //////////////////////////////
    // alu lane
    //////////////////////////////

    rs_station #(.payload_t(ooo_pkg::alu_op_t), .issue_t(ooo_pkg::alu_issue_t)) alu_rs_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .enable      (alu_enable),
        .entry_in    (dispatch),
        .entry_op    (dispatch.alu_op),
        .unit_free   (alu_free),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .issue_valid (alu_issue_valid),
        .issue_pkt   (alu_issue_pkt),
        .full        (alu_full)
    );

    alu_unit alu_unit_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (alu_issue_valid),
        .issue_pkt   (alu_issue_pkt),
        .grant       (alu_grant),
        .result      (alu_result),
        .free        (alu_free)
    );

    //////////////////////////////
    // mul lane
    //////////////////////////////

    rs_station #(.payload_t(ooo_pkg::mul_op_t), .issue_t(ooo_pkg::mul_issue_t)) mul_rs_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .enable      (mul_enable),
        .entry_in    (dispatch),
        .entry_op    (dispatch.mul_op),
        .unit_free   (1'b1),             // pipeline never stalls
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .issue_valid (mul_issue_valid),
        .issue_pkt   (mul_issue_pkt),
        .full        (mul_full)
    );

    mul_unit mul_unit_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (mul_issue_valid),
        .issue_pkt   (mul_issue_pkt),
        .result      (mul_result)
    );

    // merge onto the cdb, which loops back to both stations
    cdb_arbiter cdb_arbiter_i (
        .mul_result (mul_result),
        .alu_result (alu_result),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .alu_grant  (alu_grant)
    );

endmodule

/* logic/mul_unit.sv */
module mul_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                issue_valid,
    input  ooo_pkg::mul_issue_t issue_pkt,
    output ooo_pkg::result_t    result
);

    logic [ooo_pkg::mul_stages-1:0] vld;  // one valid bit per stage

    // stage 1, extended operands
    logic signed [ooo_pkg::xlen:0]  s1_a;
    logic signed [ooo_pkg::xlen:0]  s1_b;
    ooo_pkg::mul_op_t               s1_op;
    logic [ooo_pkg::prf_len-1:0]    s1_dest;
    logic [ooo_pkg::rob_len-1:0]    s1_rob;

    // stage 2, full product
    logic [2*ooo_pkg::xlen-1:0]     s2_prod;
    ooo_pkg::mul_op_t               s2_op;
    logic [ooo_pkg::prf_len-1:0]    s2_dest;
    logic [ooo_pkg::rob_len-1:0]    s2_rob;

    // stage 3, selected word
    logic [ooo_pkg::xlen-1:0]       s3_value;
    logic [ooo_pkg::prf_len-1:0]    s3_dest;
    logic [ooo_pkg::rob_len-1:0]    s3_rob;

    logic                           sign_a;
    logic                           sign_b;

    // a is signed except for mulhu, b only for mul and mulh
    assign sign_a = (issue_pkt.op != ooo_pkg::mul_mulhu) && issue_pkt.opa[ooo_pkg::xlen-1];
    assign sign_b = ((issue_pkt.op == ooo_pkg::mul_mul) || (issue_pkt.op == ooo_pkg::mul_mulh))
                    && issue_pkt.opb[ooo_pkg::xlen-1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vld <= '0;
        end else if (flush) begin
            vld <= '0;                 // kill all three in flight
        end else begin
            vld <= {vld[ooo_pkg::mul_stages-2:0], issue_valid};
        end
    end

    //////////////////////////////
    // payload pipeline
    //////////////////////////////

    always_ff @(posedge clock) begin
        s1_a    <= {sign_a, issue_pkt.opa};
        s1_b    <= {sign_b, issue_pkt.opb};
        s1_op   <= issue_pkt.op;
        s1_dest <= issue_pkt.dest_preg;
        s1_rob  <= issue_pkt.rob_idx;

        s2_prod <= s1_a * s1_b;        // 66-bit signed, low 64 kept
        s2_op   <= s1_op;
        s2_dest <= s1_dest;
        s2_rob  <= s1_rob;

        s3_value <= (s2_op == ooo_pkg::mul_mul) ? s2_prod[ooo_pkg::xlen-1:0]
                                                : s2_prod[2*ooo_pkg::xlen-1:ooo_pkg::xlen];
        s3_dest  <= s2_dest;
        s3_rob   <= s2_rob;
    end

    assign result = {vld[ooo_pkg::mul_stages-1], s3_dest, s3_rob, s3_value};

endmodule

/* rs/rs_station.sv */
module rs_station #(
    parameter type payload_t = ooo_pkg::alu_op_t,     // lane op encoding
    parameter type issue_t   = ooo_pkg::alu_issue_t   // lane issue packet
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               flush,      // mispredict, empties all entries
    input  logic               enable,     // dispatch strobe for this lane
    input  ooo_pkg::dispatch_t entry_in,
    input  payload_t           entry_op,   // lane op, picked out of entry_in by the top
    input  logic               unit_free,  // unit can take an issue next cycle
    input  logic               cdb_valid,
    input  ooo_pkg::cdb_t      cdb,
    output logic               issue_valid, // one-cycle pulse per issued entry
    output issue_t             issue_pkt,
    output logic               full
);

    // one waiting instruction
    typedef struct packed {
        payload_t                    op;
        ooo_pkg::operand_t           opa;
        ooo_pkg::operand_t           opb;
        logic [ooo_pkg::prf_len-1:0] dest_preg;
        logic [ooo_pkg::rob_len-1:0] rob_idx;
    } entry_t;

    entry_t                      entries [ooo_pkg::rs_size];
    logic [ooo_pkg::rs_size-1:0] free_mask;   // 1 = slot empty
    logic [ooo_pkg::rs_len:0]    count;       // occupied slots
    logic [ooo_pkg::rs_size-1:0] req;         // ready to go and unit free
    logic [ooo_pkg::rs_len-1:0]  free_idx;    // slot for the next dispatch
    logic [ooo_pkg::rs_len-1:0]  issue_idx;   // slot chosen to issue
    logic                        issue_fire;

    // capture a broadcast into a waiting operand, tag sits in the low bits
    function automatic ooo_pkg::operand_t wake(input ooo_pkg::operand_t opnd,
                                               input logic             bvalid,
                                               input ooo_pkg::cdb_t    bus);
        ooo_pkg::operand_t res;
        res = opnd;
        if (bvalid && !opnd.ready &&
            (opnd.value[ooo_pkg::prf_len-1:0] == bus.dest_preg)) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign full = (count == (ooo_pkg::rs_len + 1)'(ooo_pkg::rs_size));

    //////////////////////////////
    // slot selection
    //////////////////////////////

    // lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = ooo_pkg::rs_size - 1; i >= 0; i--) begin
            if (free_mask[i]) free_idx = i[ooo_pkg::rs_len-1:0];
        end
    end

    // both operands ready in an occupied slot
    always_comb begin
        for (int k = 0; k < ooo_pkg::rs_size; k++) begin
            req[k] = !free_mask[k] && entries[k].opa.ready && entries[k].opb.ready &&
                     unit_free;
        end
    end

    // lowest ready slot issues
    always_comb begin
        issue_idx = '0;
        for (int j = ooo_pkg::rs_size - 1; j >= 0; j--) begin
            if (req[j]) issue_idx = j[ooo_pkg::rs_len-1:0];
        end
    end

    assign issue_fire = |req;

    //////////////////////////////
    // control state
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            free_mask   <= '1;
            count       <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            free_mask   <= '1;  // drop everything waiting
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count <= count + {{ooo_pkg::rs_len{1'b0}}, enable}
                           - {{ooo_pkg::rs_len{1'b0}}, issue_fire};
            if (enable) free_mask[free_idx] <= 1'b0;  // claim
            if (issue_fire) free_mask[issue_idx] <= 1'b1;  // release on issue
            issue_valid <= issue_fire;
        end
    end

    //////////////////////////////
    // entry storage and wakeup
    //////////////////////////////

    always_ff @(posedge clock) begin
        // waiting operands snoop the cdb
        for (int t = 0; t < ooo_pkg::rs_size; t++) begin
            if (!free_mask[t]) begin
                entries[t].opa <= wake(entries[t].opa, cdb_valid, cdb);
                entries[t].opb <= wake(entries[t].opb, cdb_valid, cdb);
            end
        end
        // new entry, same-cycle broadcast caught on the way in
        if (enable) begin
            entries[free_idx].op        <= entry_op;
            entries[free_idx].opa       <= wake(entry_in.opa, cdb_valid, cdb);
            entries[free_idx].opb       <= wake(entry_in.opb, cdb_valid, cdb);
            entries[free_idx].dest_preg <= entry_in.dest_preg;
            entries[free_idx].rob_idx   <= entry_in.rob_idx;
        end
    end

    // issue packet, qualified by issue_valid
    always_ff @(posedge clock) begin
        if (issue_fire) begin
            issue_pkt.op        <= entries[issue_idx].op;
            issue_pkt.opa       <= entries[issue_idx].opa.value;
            issue_pkt.opb       <= entries[issue_idx].opb.value;
            issue_pkt.dest_preg <= entries[issue_idx].dest_preg;
            issue_pkt.rob_idx   <= entries[issue_idx].rob_idx;
        end
    end

endmodule

/* sim/clock_gen.sv */
module clock_gen #(
    parameter int half_period  = 5,   // ns, 10 ns clock
    parameter int reset_cycles = 10
) (
    output logic clock,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1 arst_n = 1'b1;  // release just after an edge
    end

    always #(half_period) clock = ~clock;

endmodule

/* sim/issue_cluster_properties.sv */
module issue_cluster_properties (
    input logic               clock,
    input logic               arst_n,
    input logic               flush,
    input logic               dispatch_valid,
    input ooo_pkg::dispatch_t dispatch,
    input logic               cdb_valid,
    input ooo_pkg::cdb_t      cdb,
    input ooo_pkg::result_t   alu_result,  // alu holding register
    input logic               alu_grant
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2**ooo_pkg::prf_len-1:0] live;  // dest tags dispatched, not yet broadcast
    int                             fail_count = 0;

    // outstanding view, set on dispatch and cleared by its broadcast
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            live <= '0;
        end else if (flush) begin
            live <= '0;  // everything in flight is gone
        end else begin
            if (cdb_valid) live[cdb.dest_preg] <= 1'b0;
            if (dispatch_valid) live[dispatch.dest_preg] <= 1'b1;
        end
    end

    // quiet bus while reset is held
    assert property (@(posedge clock) !arst_n |-> !cdb_valid)
        else begin
            $error("cdb_valid high during reset");
            fail_count++;
        end

    // a broadcast needs an instruction behind its tag
    assert property (@(posedge clock) disable iff (!arst_n)
        cdb_valid |-> live[cdb.dest_preg])
        else begin
            $error("broadcast of a tag with no instruction outstanding");
            fail_count++;
        end

    // held alu result stays put until granted
    assert property (@(posedge clock) disable iff (!arst_n)
        alu_result.valid && !alu_grant && !flush
        |=> alu_result.valid && $stable(alu_result.cdb))
        else begin
            $error("alu result lost while waiting for the cdb");
            fail_count++;
        end

endmodule

/* sim/issue_cluster_tb.sv */
module issue_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_total = 116;  // dispatches over all tests

    logic               clock;
    logic               arst_n;
    logic               flush;
    logic               dispatch_valid;
    ooo_pkg::dispatch_t dispatch;
    logic               alu_full;
    logic               mul_full;
    logic               cdb_valid;
    ooo_pkg::cdb_t      cdb;

    clock_gen #(.half_period(5), .reset_cycles(10)) clock_gen_i (.clock(clock), .arst_n(arst_n));

    issue_cluster dut_i (.*);

    bind issue_cluster issue_cluster_properties props_i (
        .clock(clock), .arst_n(arst_n), .flush(flush), .dispatch_valid(dispatch_valid),
        .dispatch(dispatch), .cdb_valid(cdb_valid), .cdb(cdb),
        .alu_result(alu_result), .alu_grant(alu_grant)
    );

    //////////////////////////////
    // model state, indexed by physical tag
    //////////////////////////////

    logic [31:0] reg_val [64];
    bit          pend    [64];       // instruction outstanding for this dest
    bit          p_mul   [64];
    logic [2:0]  p_aop   [64];
    logic [1:0]  p_mop   [64];
    logic [31:0] p_a     [64];       // value once known
    logic [31:0] p_b     [64];
    bit          p_a_rdy [64];
    bit          p_b_rdy [64];
    logic [5:0]  p_a_tag [64];
    logic [5:0]  p_b_tag [64];
    logic [4:0]  p_rob   [64];
    int          p_cyc   [64];       // dispatch cycle
    bit          p_lat   [64];       // check lone mul latency
    int          lane_cnt [2];       // outstanding per lane
    int          n_pend, cyc, errors, passed, failed;
    integer      seed;
    logic [4:0]  rob_next;
    string       cur_test;

    // reference result straight from the ISA rules
    function automatic logic [31:0] expect_value(input bit is_mul, input logic [2:0] aop,
                                                 input logic [1:0] mop,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};   // low 64 bits are exact
        p_su = {{32{a[31]}}, a} * {32'b0, b};
        p_uu = {32'b0, a} * {32'b0, b};
        if (is_mul) begin
            case (mop)
                2'd0: return p_ss[31:0];
                2'd1: return p_ss[63:32];
                2'd2: return p_su[63:32];
                default: return p_uu[63:32];
            endcase
        end
        case (aop)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return {31'b0, $signed(a) < $signed(b)};
            3'd6: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // operand source: an outstanding tag now and then, else a completed register
    task automatic pick_src(input bit dep_ok, input logic [31:0] val,
                            output ooo_pkg::operand_t o, output bit rdy,
                            output logic [5:0] tag);
        logic [5:0] t;
        rdy = 1'b1;
        tag = '0;
        o   = {1'b1, val};
        if (dep_ok && n_pend > 0 && ($random(seed) & 1)) begin
            for (int i = 0; i < 16; i++) begin
                t = $random(seed);
                if (pend[t] && rdy) begin
                    rdy = 1'b0;
                    tag = t;
                    o   = {1'b0, 26'b0, t};  // tag in the low bits
                end
            end
        end
        if (dep_ok && rdy) begin
            t = $random(seed);
            if (!pend[t]) o = {1'b1, reg_val[t]};  // done register, sent with its value
        end
    endtask

    task automatic send(input bit is_mul, input logic [2:0] aop, input logic [1:0] mop,
                        input bit dep_ok, input logic [31:0] av, input logic [31:0] bv,
                        input bit lat_chk);
        ooo_pkg::operand_t oa;
        ooo_pkg::operand_t ob;
        bit               ra, rb;
        logic [5:0]       ta, tb, d;
        next_cycle();
        // full only when the lane really holds four or more
        assert (!alu_full || lane_cnt[0] >= ooo_pkg::rs_size) else begin
            $display("%s: alu_full high with too few ALU instructions outstanding", cur_test);
            errors++;
        end
        assert (!mul_full || lane_cnt[1] >= ooo_pkg::rs_size) else begin
            $display("%s: mul_full high with too few multiplies outstanding", cur_test);
            errors++;
        end
        while (is_mul ? mul_full : alu_full) next_cycle();
        pick_src(dep_ok, av, oa, ra, ta);
        pick_src(dep_ok, bv, ob, rb, tb);
        do d = $random(seed); while (pend[d]);   // unique among outstanding
        pend[d]    = 1;
        p_mul[d]   = is_mul;
        p_aop[d]   = aop;
        p_mop[d]   = mop;
        p_a[d]     = oa.value;  // tag bits until woken
        p_b[d]     = ob.value;
        p_a_rdy[d] = ra;
        p_b_rdy[d] = rb;
        p_a_tag[d] = ta;
        p_b_tag[d] = tb;
        p_rob[d]   = rob_next;
        p_cyc[d]   = cyc;
        p_lat[d]   = lat_chk;
        lane_cnt[is_mul]++;
        n_pend++;
        dispatch.fu_sel    = is_mul ? ooo_pkg::fu_mul : ooo_pkg::fu_alu;
        dispatch.alu_op    = ooo_pkg::alu_op_t'(aop);
        dispatch.mul_op    = ooo_pkg::mul_op_t'(mop);
        dispatch.opa       = oa;
        dispatch.opb       = ob;
        dispatch.dest_preg = d;
        dispatch.rob_idx   = rob_next;
        dispatch_valid     = 1'b1;
        rob_next++;
    endtask

    task automatic drain();
        while (n_pend > 0) next_cycle();
    endtask

    task automatic finish_test(input int err_start);
        if (errors == err_start) begin
            passed++;
            $display("test %s: ok", cur_test);
        end else begin
            failed++;
            $display("test %s: %0d errors", cur_test, errors - err_start);
        end
    endtask

    //////////////////////////////
    // cdb monitor, mid-cycle sample
    //////////////////////////////

    always @(posedge clock) cyc <= cyc + 1;

    always @(negedge clock) begin
        logic [5:0]  d;
        logic [31:0] exp_v;
        if (arst_n && cdb_valid) begin
            d = cdb.dest_preg;
            if (!pend[d]) begin
                $display("%s: broadcast of tag %0d with nothing outstanding", cur_test, d);
                errors++;
            end else begin
                assert (p_a_rdy[d] && p_b_rdy[d]) else begin
                    $display("%s: tag %0d broadcast before its sources", cur_test, d);
                    errors++;
                end
                exp_v = expect_value(p_mul[d], p_aop[d], p_mop[d], p_a[d], p_b[d]);
                assert (cdb.value == exp_v) else begin
                    $display("mismatch %s tag %0d expected %h actual %h", cur_test, d,
                             exp_v, cdb.value);
                    errors++;
                end
                assert (cdb.rob_idx == p_rob[d]) else begin
                    $display("mismatch %s rob_idx of tag %0d expected %0d actual %0d",
                             cur_test, d, p_rob[d], cdb.rob_idx);
                    errors++;
                end
                // dispatch edge to broadcast is mul_stages + 1 edges
                if (p_lat[d]) begin
                    assert (cyc - p_cyc[d] - 1 == ooo_pkg::mul_stages + 1) else begin
                        $display("mismatch %s latency expected %0d actual %0d", cur_test,
                                 ooo_pkg::mul_stages + 1, cyc - p_cyc[d] - 1);
                        errors++;
                    end
                end
                pend[d] = 0;
                reg_val[d] = exp_v;
                lane_cnt[p_mul[d]]--;
                n_pend--;
                // waiting consumers pick up the value now
                for (int t = 0; t < 64; t++) begin
                    if (pend[t] && !p_a_rdy[t] && p_a_tag[t] == d) begin
                        p_a[t] = exp_v;
                        p_a_rdy[t] = 1;
                    end
                    if (pend[t] && !p_b_rdy[t] && p_b_tag[t] == d) begin
                        p_b[t] = exp_v;
                        p_b_rdy[t] = 1;
                    end
                end
            end
        end
    end

    // watchdog, 200 cycles per dispatch on top of reset
    initial begin
        repeat (10 + 200 * n_total) @(posedge clock);
        $display("watchdog: run did not finish in time, %0d instructions stuck", n_pend);
        $display("=== FAIL ===");
        $finish;
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        int e0;
        logic [31:0] ext [5];
        seed = 97;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        cyc = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        n_pend = 0;
        rob_next = '0;
        lane_cnt[0] = 0;
        lane_cnt[1] = 0;
        for (int t = 0; t < 64; t++) begin
            pend[t] = 0;
            reg_val[t] = $random(seed);
        end
        ext = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h1, 32'h0};
        wait (arst_n);

        cur_test = "alu_ops";
        e0 = errors;
        for (int i = 0; i < 16; i++) send(0, i % 8, 0, 0, $random(seed), $random(seed), 0);
        next_cycle();
        drain();
        finish_test(e0);

        cur_test = "mul_extremes";
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            // first four ops take 0x80000000 squared
            send(1, 0, i % 4, 0, ext[i / 4], ext[(3 * (i / 4)) % 5], 1);
            next_cycle();
            drain();
        end
        finish_test(e0);

        cur_test = "dep_chains";
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            send($random(seed) & 1, $random(seed), $random(seed), 1,
                 $random(seed), $random(seed), 0);
            repeat ($unsigned($random(seed)) % 3) next_cycle();
        end
        next_cycle();
        drain();
        finish_test(e0);

        cur_test = "contention";
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            send(($random(seed) % 3) == 0, $random(seed), $random(seed), 1,
                 $random(seed), $random(seed), 0);
        end
        next_cycle();
        drain();
        finish_test(e0);

        cur_test = "flush";
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            send(i % 2, $random(seed), $random(seed), 1, $random(seed), $random(seed), 0);
        end
        next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // flushed tags never broadcast, sources reuse the last known value
        for (int t = 0; t < 64; t++) pend[t] = 0;
        lane_cnt[0] = 0;
        lane_cnt[1] = 0;
        n_pend = 0;
        next_cycle();
        assert (!alu_full && !mul_full) else begin
            $display("%s: full level still high after flush", cur_test);
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            send(i % 2, $random(seed), $random(seed), 1, $random(seed), $random(seed), 0);
        end
        next_cycle();
        drain();
        repeat (8) next_cycle();  // any late broadcast shows up here
        finish_test(e0);

        if (dut_i.props_i.fail_count != 0) begin
            $display("bound assertions failed %0d times", dut_i.props_i.fail_count);
            errors += dut_i.props_i.fail_count;
        end
        $display("tests passed %0d failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
